// ==== src/ion_packet_pkg.sv ====
// Sensor packet layout, fixed field values and recorded table depth.

package ion_packet_pkg;

	// Packet fields listed from the most significant bit down.
	// The header sits in the lowest seven bits on the wire.
	typedef struct packed {
		logic [23:0] sensor_id;
		logic [5:0]  channel;
		logic [15:0] reading;
		logic [7:0]  tag_low;
		logic [7:0]  tag_high;
		logic [15:0] timestamp;
		logic [7:0]  gain;
		logic [7:0]  ion_level;
		logic [7:0]  marker;
		logic        polarity;
		logic [6:0]  header;
	} ion_packet_t;

	// Fields that carry the same value in every recorded sample.
	localparam logic [6:0]  HEADER_VALUE    = 7'd77;
	localparam logic [7:0]  MARKER_VALUE    = 8'd255;
	localparam logic [7:0]  TAG_HIGH_VALUE  = 8'd239;
	localparam logic [7:0]  TAG_LOW_VALUE   = 8'd17;
	localparam logic [5:0]  CHANNEL_VALUE   = 6'd1;
	localparam logic [23:0] SENSOR_ID_VALUE = 24'd4272433;

	// Number of recorded samples kept in the packet table.
	localparam int unsigned TABLE_DEPTH = 16;

endpackage

// ==== src/ion_control_pkg.sv ====
// Sequencer state encoding, sample interval and counter widths.

package ion_control_pkg;

	typedef enum logic [1:0] {
		STATE_START = 2'b00,
		STATE_IDLE  = 2'b01,
		STATE_READ  = 2'b10,
		STATE_SEND  = 2'b11
	} seq_state_t;

	// Idle cycles between two samples.
	localparam int unsigned SAMPLE_INTERVAL = 8;

	// Wide enough to hold the table depth itself, which marks the end of the table.
	localparam int unsigned INDEX_WIDTH = 5;

	typedef logic [INDEX_WIDTH-1:0] table_index_t;

	localparam int unsigned TIMER_WIDTH = 16;

endpackage

// ==== src/sample_timer.sv ====
// Idle cycle counter that flags the last cycle of a sample interval.

`timescale 1ns/1ns

module sample_timer
	import ion_control_pkg::*;
(
	input  logic clock,
	input  logic resetn,
	input  logic counting,
	input  logic read_strobe,
	output logic interval_done
);

	logic [TIMER_WIDTH-1:0] idle_count;

	// The read cycle clears the count so the next idle period starts from zero.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			idle_count <= '0;
		end
		else if (read_strobe)
		begin
			idle_count <= '0;
		end
		else if (counting)
		begin
			idle_count <= idle_count + 1'b1;
		end
	end

	assign interval_done = (idle_count == TIMER_WIDTH'(SAMPLE_INTERVAL - 1));

endmodule

// ==== src/packet_sequencer.sv ====
// Start, idle, read and send FSM with the table index it walks through.

`timescale 1ns/1ns

module packet_sequencer
	import ion_packet_pkg::*;
	import ion_control_pkg::*;
(
	input  logic         clock,
	input  logic         resetn,
	input  logic         interval_done,
	output logic         counting,
	output logic         read_strobe,
	output table_index_t read_index,
	output logic         packet_valid
);

	seq_state_t state;
	seq_state_t next_state;

	always_comb
	begin
		case (state)
			STATE_START:
			begin
				next_state = STATE_IDLE;
			end
			STATE_IDLE:
			begin
				next_state = interval_done ? STATE_READ : STATE_IDLE;
			end
			STATE_READ:
			begin
				next_state = STATE_SEND;
			end
			STATE_SEND:
			begin
				next_state = STATE_IDLE;
			end
			default:
			begin
				next_state = STATE_START;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= STATE_START;
		end
		else
		begin
			state <= next_state;
		end
	end

	// Step to the next entry once the current one has been sent.
	// The index stops at the table depth, past the last recorded sample.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			read_index <= '0;
		end
		else if (state == STATE_SEND && read_index != table_index_t'(TABLE_DEPTH))
		begin
			read_index <= read_index + 1'b1;
		end
	end

	assign counting     = (state == STATE_IDLE);
	assign read_strobe  = (state == STATE_READ);
	assign packet_valid = (state == STATE_SEND);

endmodule

// ==== src/packet_rom.sv ====
// Recorded ion samples and the registered packet built from them.

`timescale 1ns/1ns

module packet_rom
	import ion_packet_pkg::*;
	import ion_control_pkg::*;
(
	input  logic         clock,
	input  logic         resetn,
	input  logic         read_strobe,
	input  table_index_t read_index,
	output ion_packet_t  packet
);

	// Only the fields that differ between samples are stored.
	typedef struct packed {
		logic        polarity;
		logic [7:0]  ion_level;
		logic [7:0]  gain;
		logic [15:0] timestamp;
		logic [15:0] reading;
	} sample_t;

	localparam sample_t SAMPLE_TABLE [TABLE_DEPTH] = '{
		'{polarity: 1'b0, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd881, reading: 16'd56110},
		'{polarity: 1'b1, ion_level: 8'd176, gain: 8'd100,
		  timestamp: 16'd925, reading: 16'd3791},
		'{polarity: 1'b0, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd962, reading: 16'd63275},
		'{polarity: 1'b1, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd1011, reading: 16'd24574},
		'{polarity: 1'b1, ion_level: 8'd185, gain: 8'd100,
		  timestamp: 16'd1045, reading: 16'd40019},
		'{polarity: 1'b1, ion_level: 8'd186, gain: 8'd100,
		  timestamp: 16'd1094, reading: 16'd50527},
		'{polarity: 1'b0, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd1136, reading: 16'd60177},
		'{polarity: 1'b0, ion_level: 8'd178, gain: 8'd100,
		  timestamp: 16'd1178, reading: 16'd47222},
		'{polarity: 1'b0, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd1220, reading: 16'd42756},
		'{polarity: 1'b0, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd1262, reading: 16'd61961},
		'{polarity: 1'b0, ion_level: 8'd183, gain: 8'd100,
		  timestamp: 16'd1304, reading: 16'd7993},
		'{polarity: 1'b0, ion_level: 8'd178, gain: 8'd100,
		  timestamp: 16'd1346, reading: 16'd17675},
		'{polarity: 1'b0, ion_level: 8'd178, gain: 8'd100,
		  timestamp: 16'd1380, reading: 16'd57473},
		'{polarity: 1'b0, ion_level: 8'd177, gain: 8'd100,
		  timestamp: 16'd1430, reading: 16'd53224},
		'{polarity: 1'b0, ion_level: 8'd178, gain: 8'd100,
		  timestamp: 16'd1472, reading: 16'd61195},
		'{polarity: 1'b1, ion_level: 8'd185, gain: 8'd100,
		  timestamp: 16'd1514, reading: 16'd46996}
	};

	logic [$clog2(TABLE_DEPTH)-1:0] rom_addr;
	logic                           in_range;
	sample_t                        entry;
	ion_packet_t                    next_packet;

	assign rom_addr = read_index[$clog2(TABLE_DEPTH)-1:0];
	assign in_range = (read_index < table_index_t'(TABLE_DEPTH));
	assign entry    = SAMPLE_TABLE[rom_addr];

	always_comb
	begin
		next_packet.sensor_id = SENSOR_ID_VALUE;
		next_packet.channel   = CHANNEL_VALUE;
		next_packet.reading   = entry.reading;
		next_packet.tag_low   = TAG_LOW_VALUE;
		next_packet.tag_high  = TAG_HIGH_VALUE;
		next_packet.timestamp = entry.timestamp;
		next_packet.gain      = entry.gain;
		next_packet.ion_level = entry.ion_level;
		next_packet.marker    = MARKER_VALUE;
		next_packet.polarity  = entry.polarity;
		next_packet.header    = HEADER_VALUE;
	end

	// Past the last sample the sensor reports an empty packet.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			packet <= '0;
		end
		else if (read_strobe)
		begin
			packet <= in_range ? next_packet : '0;
		end
	end

endmodule

// ==== src/ion_sensor_top.sv ====
// Ion sensor replay top level with timer, sequencer and packet table.

`timescale 1ns/1ns

module ion_sensor_top
	import ion_packet_pkg::*;
	import ion_control_pkg::*;
(
	input  logic        clock,
	input  logic        resetn,
	output ion_packet_t packet,
	output logic        packet_valid
);

	logic         interval_done;
	logic         counting;
	logic         read_strobe;
	table_index_t read_index;

	sample_timer sample_timer_inst (
		.clock         (clock),
		.resetn        (resetn),
		.counting      (counting),
		.read_strobe   (read_strobe),
		.interval_done (interval_done)
	);

	packet_sequencer packet_sequencer_inst (
		.clock         (clock),
		.resetn        (resetn),
		.interval_done (interval_done),
		.counting      (counting),
		.read_strobe   (read_strobe),
		.read_index    (read_index),
		.packet_valid  (packet_valid)
	);

	// The packet is loaded during read, one cycle ahead of the valid strobe.
	packet_rom packet_rom_inst (
		.clock       (clock),
		.resetn      (resetn),
		.read_strobe (read_strobe),
		.read_index  (read_index),
		.packet      (packet)
	);

endmodule

// ==== verification/ion_sensor_assert.sv ====
// Bound assertions on reset values, packet timing, fixed fields and table order.

`timescale 1ns/1ns

module ion_sensor_assert
	import ion_packet_pkg::*;
	import ion_control_pkg::*;
(
	input logic        clock,
	input logic        resetn,
	input ion_packet_t packet,
	input logic        packet_valid
);

	localparam logic [7:0] PACKET_PERIOD = 8'(SAMPLE_INTERVAL + 2);
	localparam logic [7:0] DEPTH         = 8'(TABLE_DEPTH);

	int unsigned failure_count = 0;
	logic [7:0]  since_valid;
	logic [7:0]  valid_count;
	logic [15:0] last_timestamp;
	logic        first_captured = 1'b0;
	logic [15:0] first_timestamp = '0;

	// Cycles since reset release or since the last valid packet.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			since_valid    <= '0;
			valid_count    <= '0;
			last_timestamp <= '0;
		end
		else
		begin
			since_valid <= packet_valid ? 8'd1 : since_valid + 8'd1;
			if (packet_valid)
			begin
				last_timestamp <= packet.timestamp;
				if (valid_count != 8'hff)
				begin
					valid_count <= valid_count + 8'd1;
				end
			end
		end
	end

	// Remembers the first timestamp of the whole run, across every reset.
	always_ff @(posedge clock)
	begin
		if (resetn && packet_valid && !first_captured)
		begin
			first_captured  <= 1'b1;
			first_timestamp <= packet.timestamp;
		end
	end

	reset_clears: assert property (@(posedge clock)
		(!resetn || !$past(resetn)) |-> (!packet_valid && packet == '0))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: packet or packet_valid not clear around reset", $time);
	end

	valid_period: assert property (@(posedge clock) disable iff (!resetn)
		packet_valid == (since_valid == PACKET_PERIOD))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: packet_valid off its sample period", $time);
	end

	valid_single: assert property (@(posedge clock) disable iff (!resetn)
		packet_valid |=> !packet_valid)
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: packet_valid longer than one cycle", $time);
	end

	fixed_fields: assert property (@(posedge clock) disable iff (!resetn)
		(packet_valid && valid_count < DEPTH) |->
		(packet.header == HEADER_VALUE && packet.marker == MARKER_VALUE &&
		 packet.tag_high == TAG_HIGH_VALUE && packet.tag_low == TAG_LOW_VALUE &&
		 packet.channel == CHANNEL_VALUE && packet.sensor_id == SENSOR_ID_VALUE))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: fixed packet field differs from its constant", $time);
	end

	timestamp_rising: assert property (@(posedge clock) disable iff (!resetn)
		(packet_valid && valid_count != 8'd0 && valid_count < DEPTH) |->
		(packet.timestamp > last_timestamp))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: timestamp %0d not above %0d", $time,
			packet.timestamp, last_timestamp);
	end

	tail_zero: assert property (@(posedge clock) disable iff (!resetn)
		(packet_valid && valid_count >= DEPTH) |-> (packet == '0))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: packet past the table end is not zero", $time);
	end

	hold_between: assert property (@(posedge clock) disable iff (!resetn)
		(!$past(packet_valid) && !packet_valid) |-> $stable(packet))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: packet changed between strobes", $time);
	end

	restart_at_entry0: assert property (@(posedge clock) disable iff (!resetn)
		(packet_valid && valid_count == 8'd0 && first_captured) |->
		(packet.timestamp == first_timestamp))
	else
	begin
		failure_count = failure_count + 1;
		$error("Mismatch at %0t: first packet after reset is not entry 0", $time);
	end

endmodule

bind ion_sensor_top ion_sensor_assert ion_sensor_assert_inst (
	.clock        (clock),
	.resetn       (resetn),
	.packet       (packet),
	.packet_valid (packet_valid)
);

// ==== verification/ion_sensor_tb.sv ====
// Testbench for the ion sensor replay with clock, reset sequence, timeout and result report.

`timescale 1ns/1ns

module ion_sensor_tb
	import ion_packet_pkg::*;
	import ion_control_pkg::*;
();

	localparam int unsigned PACKET_PERIOD      = SAMPLE_INTERVAL + 2;
	localparam int unsigned TIMEOUT_CYCLES     = 4 * 25 * PACKET_PERIOD;
	localparam int unsigned RESET_CYCLES       = 4;
	localparam int unsigned FIRST_RUN_PACKETS  = 20;
	localparam int unsigned SECOND_RUN_PACKETS = 3;

	logic        clock;
	logic        resetn;
	ion_packet_t packet;
	logic        packet_valid;
	int unsigned cycle_count = 0;
	int unsigned packets_seen = 0;

	ion_sensor_top ion_sensor_top_inst (
		.clock        (clock),
		.resetn       (resetn),
		.packet       (packet),
		.packet_valid (packet_valid)
	);

	initial
	begin
		clock = 1'b0;
		resetn = 1'b0;
	end

	always #5 clock = ~clock;

	// Holds reset low from the current falling edge for the given number of cycles.
	task automatic apply_reset(input int unsigned cycles);
		resetn = 1'b0;
		repeat (cycles) @(negedge clock);
		resetn = 1'b1;
	endtask

	// Counts valid strobes on falling edges, where packet_valid is settled.
	task automatic wait_for_packets(input int unsigned count);
		int unsigned seen;
		seen = 0;
		while (seen < count)
		begin
			@(negedge clock);
			if (packet_valid)
			begin
				seen++;
				packets_seen++;
			end
		end
	endtask

	task automatic finish_run();
		int unsigned failures;
		failures = ion_sensor_top_inst.ion_sensor_assert_inst.failure_count;
		$display("Observed %0d valid packets in %0d cycles", packets_seen, cycle_count);
		if (failures != 0)
		begin
			$display("%0d assertion failures", failures);
			$display("SOME TESTS FAILED");
			$fatal(1, "Assertion failures found at the end of the run");
		end
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	endtask

	initial
	begin
		apply_reset(RESET_CYCLES);
		wait_for_packets(FIRST_RUN_PACKETS);

		// A second reset in the middle of the run must restart the table at entry 0.
		apply_reset(RESET_CYCLES);
		wait_for_packets(SECOND_RUN_PACKETS);

		repeat (PACKET_PERIOD) @(negedge clock);
		finish_run();
	end

	// Stops at the first failed assertion.
	always @(negedge clock)
	begin
		if (ion_sensor_top_inst.ion_sensor_assert_inst.failure_count != 0)
		begin
			$display("An assertion failed at %0t", $time);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stopped at the first failed assertion");
		end
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "Timeout");
		end
	end

endmodule

// ==== sources.f ====
src/ion_packet_pkg.sv
src/ion_control_pkg.sv
src/sample_timer.sv
src/packet_sequencer.sv
src/packet_rom.sv
src/ion_sensor_top.sv
verification/ion_sensor_assert.sv
verification/ion_sensor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ion_sensor_tb \
	-f sources.f -o ion_sensor_sim

if ./obj_dir/ion_sensor_sim +verilator+error+limit+100 > sim.log 2>&1; then
	echo "Simulator exited normally"
fi
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
